//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := cart_cheat_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(SIM_LOG)
	@if grep -q "Verification failed" $(SIM_LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Verification passed" $(SIM_LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

//--- bench/cart_cheat_tb.sv
`timescale 1ns/1ps

module cart_cheat_tb;

  localparam int NUM_SLOTS  = 6;
  localparam int RD_TIMEOUT = 20;

  typedef enum logic [1:0] {
    STEP_MCU,
    STEP_WR,
    STEP_RD
  } step_e;

  logic        clk;
  logic        rst;
  logic        bus_wr_strobe;
  logic        bus_rd_strobe;
  logic [23:0] bus_addr;
  logic [7:0]  bus_wr_data;
  logic [7:0]  rom_data;
  logic        mcu_strobe;
  logic [7:0]  mcu_byte;
  logic        rd_valid;
  logic [7:0]  rd_data;
  logic        cheat_hit;

  // Step table, MCU steps keep the header in the address column
  step_e       step_kind[$];
  logic [23:0] step_addr[$];
  logic [31:0] step_data[$];
  logic        step_hit[$];

  // Reference model of the slot table and enables
  logic [23:0] ref_addr[NUM_SLOTS];
  logic [7:0]  ref_data[NUM_SLOTS];
  logic [5:0]  ref_mask;
  logic        ref_cheat;
  logic        ref_hook;

  logic [31:0] lfsr;

  cart_cheat_top #(.NUM_SLOTS(NUM_SLOTS)) cart_cheat_top_i (
    .clk           (clk),
    .rst           (rst),
    .bus_wr_strobe (bus_wr_strobe),
    .bus_rd_strobe (bus_rd_strobe),
    .bus_addr      (bus_addr),
    .bus_wr_data   (bus_wr_data),
    .rom_data      (rom_data),
    .mcu_strobe    (mcu_strobe),
    .mcu_byte      (mcu_byte),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .cheat_hit     (cheat_hit)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp));
    end
  endtask

  task automatic add_step(input step_e kind, input logic [23:0] addr,
                          input logic [31:0] data, input logic hit);
    step_kind.push_back(kind);
    step_addr.push_back(addr);
    step_data.push_back(data);
    step_hit.push_back(hit);
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  task automatic ref_mcu(input logic [7:0] hdr, input logic [31:0] pay);
    int idx;
    idx = int'(hdr[3:0]);
    if (hdr[7:4] == 4'd1 && idx < NUM_SLOTS) begin
      ref_addr[idx] = pay[31:8];
      ref_data[idx] = pay[7:0];
    end else if (hdr[7:4] == 4'd2) begin
      ref_hook  = pay[7];
      ref_cheat = pay[6];
      ref_mask  = pay[5:0];
    end
  endtask

  task automatic ref_wr(input logic [23:0] addr, input logic [7:0] data);
    if (addr == 24'h002A00) begin
      case (data)
        8'h82:   ref_cheat = 1'b1;
        8'h83:   ref_cheat = 1'b0;
        8'h84:   ref_hook  = 1'b0;
        default: ;
      endcase
    end
  endtask

  // Hit flag above the expected byte
  function automatic logic [8:0] ref_read(input logic [23:0] addr, input logic [7:0] rom);
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (ref_cheat && ref_mask[i] && addr == ref_addr[i]) begin
        return {1'b1, ref_data[i]};
      end
    end
    if (ref_hook && addr == 24'h00FFEB) begin
      return {1'b1, 8'h20};
    end
    if (ref_hook && addr == 24'h00FFEA) begin
      return {1'b1, 8'h2A};
    end
    return {1'b0, rom};
  endfunction

  ////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////
  task automatic send_byte(input logic [7:0] b);
    @(negedge clk);
    mcu_strobe = 1'b1;
    mcu_byte   = b;
    @(negedge clk);
    mcu_strobe = 1'b0;
  endtask

  // Unknown opcodes go out as a bare header
  task automatic send_frame(input logic [7:0] hdr, input logic [31:0] pay);
    int gap;
    send_byte(hdr);
    if (hdr[7:4] == 4'd1 || hdr[7:4] == 4'd2) begin
      for (int i = 3; i >= 0; i--) begin
        gap = int'(rand_bits(2));
        repeat (gap) @(negedge clk);
        send_byte(pay[i*8 +: 8]);
      end
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic bus_write(input logic [23:0] addr, input logic [7:0] data);
    @(negedge clk);
    bus_wr_strobe = 1'b1;
    bus_addr      = addr;
    bus_wr_data   = data;
    @(negedge clk);
    bus_wr_strobe = 1'b0;
    repeat (3) @(negedge clk);
  endtask

  task automatic bus_read(input logic [23:0] addr, input logic exp_hit);
    logic [7:0] rom;
    logic [8:0] exp;
    int         waited;
    rom = 8'(rand_bits(8));
    exp = ref_read(addr, rom);
    if (exp[8] !== exp_hit) begin
      abort_run($sformatf("Step table and reference model disagree on the hit at %06h", addr));
    end
    @(negedge clk);
    bus_rd_strobe = 1'b1;
    bus_addr      = addr;
    rom_data      = rom;
    @(negedge clk);
    bus_rd_strobe = 1'b0;
    // ROM byte only counts in the strobe cycle
    rom_data      = ~rom;
    waited        = 0;
    while (!rd_valid) begin
      if (waited == RD_TIMEOUT) begin
        abort_run("Timed out waiting for rd_valid after a console read");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    // Response is due one cycle after the strobe
    check("rd_valid wait cycles", 32'(waited), 32'd0);
    check("cheat_hit", 32'(cheat_hit), 32'(exp_hit));
    check("rd_data", 32'(rd_data), 32'(exp[7:0]));
    @(negedge clk);
    check("rd_valid", 32'(rd_valid), 32'd0);
  endtask

  ////////////////////////////////////////
  // Step table
  ////////////////////////////////////////
  task automatic build_table();
    // Nothing substitutes after reset
    add_step(STEP_RD, 24'h00FFEA, 32'h0, 1'b0);
    add_step(STEP_RD, 24'h00FFEB, 32'h0, 1'b0);
    add_step(STEP_RD, 24'h123456, 32'h0, 1'b0);
    add_step(STEP_RD, 24'h002A00, 32'h0, 1'b0);
    // Slots 0 and 2 share an address
    add_step(STEP_MCU, 24'h000010, 32'h123456A5, 1'b0);
    add_step(STEP_MCU, 24'h000011, 32'h0180005A, 1'b0);
    add_step(STEP_MCU, 24'h000012, 32'h12345677, 1'b0);
    add_step(STEP_MCU, 24'h000013, 32'h7E00103C, 1'b0);
    add_step(STEP_RD, 24'h123456, 32'h0, 1'b0);
    // Hook and cheats on, mask 000101
    add_step(STEP_MCU, 24'h000020, 32'h000000C5, 1'b0);
    add_step(STEP_RD, 24'h123456, 32'h0, 1'b1);
    add_step(STEP_RD, 24'h018000, 32'h0, 1'b0);
    add_step(STEP_RD, 24'h7E0010, 32'h0, 1'b0);
    add_step(STEP_RD, 24'h00FFEA, 32'h0, 1'b1);
    add_step(STEP_RD, 24'h00FFEB, 32'h0, 1'b1);
    // Slot 0 off so slot 2 serves the shared address
    add_step(STEP_MCU, 24'h000020, 32'h000000C4, 1'b0);
    add_step(STEP_RD, 24'h123456, 32'h0, 1'b1);
    add_step(STEP_MCU, 24'h000020, 32'h000000C7, 1'b0);
    add_step(STEP_RD, 24'h018000, 32'h0, 1'b1);
    add_step(STEP_RD, 24'h123456, 32'h0, 1'b1);
    // Command window, only the base address and known bytes count
    add_step(STEP_WR, 24'h002A00, 32'h83, 1'b0);
    add_step(STEP_RD, 24'h123456, 32'h0, 1'b0);
    add_step(STEP_RD, 24'h00FFEA, 32'h0, 1'b1);
    add_step(STEP_WR, 24'h002A01, 32'h82, 1'b0);
    add_step(STEP_RD, 24'h123456, 32'h0, 1'b0);
    add_step(STEP_WR, 24'h002A00, 32'h85, 1'b0);
    add_step(STEP_RD, 24'h018000, 32'h0, 1'b0);
    add_step(STEP_WR, 24'h002A00, 32'h82, 1'b0);
    add_step(STEP_RD, 24'h123456, 32'h0, 1'b1);
    add_step(STEP_WR, 24'h002A01, 32'h83, 1'b0);
    add_step(STEP_RD, 24'h018000, 32'h0, 1'b1);
    add_step(STEP_WR, 24'h002A00, 32'h84, 1'b0);
    add_step(STEP_RD, 24'h00FFEA, 32'h0, 1'b0);
    add_step(STEP_RD, 24'h00FFEB, 32'h0, 1'b0);
    add_step(STEP_RD, 24'h123456, 32'h0, 1'b1);
    // Out of range slots and a bare unknown header, then slot 4
    // Index 9 aliases slot 1 in its low three bits
    add_step(STEP_MCU, 24'h000016, 32'h123456EE, 1'b0);
    add_step(STEP_MCU, 24'h000019, 32'h005555EE, 1'b0);
    add_step(STEP_MCU, 24'h000030, 32'h0, 1'b0);
    add_step(STEP_MCU, 24'h000014, 32'h00444499, 1'b0);
    add_step(STEP_MCU, 24'h000020, 32'h0000005F, 1'b0);
    add_step(STEP_RD, 24'h004444, 32'h0, 1'b1);
    add_step(STEP_RD, 24'h123456, 32'h0, 1'b1);
    add_step(STEP_RD, 24'h7E0010, 32'h0, 1'b1);
    add_step(STEP_RD, 24'h018000, 32'h0, 1'b1);
    add_step(STEP_RD, 24'h005555, 32'h0, 1'b0);
    add_step(STEP_RD, 24'h00FFEA, 32'h0, 1'b0);
  endtask

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    bus_wr_strobe = 1'b0;
    bus_rd_strobe = 1'b0;
    bus_addr      = '0;
    bus_wr_data   = '0;
    rom_data      = '0;
    mcu_strobe    = 1'b0;
    mcu_byte      = '0;
    lfsr          = 32'h0ab465a0;
    ref_mask      = '0;
    ref_cheat     = 1'b0;
    ref_hook      = 1'b0;
    build_table();
    repeat (4) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    for (int s = 0; s < step_kind.size(); s++) begin
      case (step_kind[s])
        STEP_MCU: begin
          send_frame(step_addr[s][7:0], step_data[s]);
          ref_mcu(step_addr[s][7:0], step_data[s]);
        end
        STEP_WR: begin
          bus_write(step_addr[s], step_data[s][7:0]);
          ref_wr(step_addr[s], step_data[s][7:0]);
        end
        default: bus_read(step_addr[s], step_hit[s]);
      endcase
    end
    $display("Verification passed");
    $finish;
  end

endmodule

//--- logic/cart_bus_pkg.sv
package cart_bus_pkg;

  ////////////////////////////////////////
  // Console bus geometry
  ////////////////////////////////////////
  localparam int ADDR_W = 24;
  localparam int DATA_W = 8;

  // Console command window, commands land on the low byte zero address
  localparam logic [ADDR_W-1:0] CMD_WINDOW_BASE = 24'h002A00;

  // Hook vectors and the bytes returned there
  localparam logic [ADDR_W-1:0] HOOK_VEC_LO  = 24'h00FFEA;
  localparam logic [ADDR_W-1:0] HOOK_VEC_HI  = 24'h00FFEB;
  localparam logic [DATA_W-1:0] HOOK_DATA_LO = 8'h2A;
  localparam logic [DATA_W-1:0] HOOK_DATA_HI = 8'h20;

  // Command window opcodes
  typedef enum logic [DATA_W-1:0] {
    CMD_NONE      = 8'h00,
    CMD_CHEAT_ON  = 8'h82,
    CMD_CHEAT_OFF = 8'h83,
    CMD_HOOK_OFF  = 8'h84
  } snescmd_op_e;

endpackage

//--- logic/cart_cheat_top.sv
`timescale 1ns/1ps

module cart_cheat_top
  import cart_bus_pkg::*;
  import cheat_pkg::*;
#(
  parameter int NUM_SLOTS = NUM_SLOTS_DEF
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              bus_wr_strobe,
  input  logic              bus_rd_strobe,
  input  logic [ADDR_W-1:0] bus_addr,
  input  logic [DATA_W-1:0] bus_wr_data,
  input  logic [DATA_W-1:0] rom_data,
  input  logic              mcu_strobe,
  input  logic [7:0]        mcu_byte,
  output logic              rd_valid,
  output logic [DATA_W-1:0] rd_data,
  output logic              cheat_hit
);

  logic                 cmd_strobe;
  snescmd_op_e          cmd_op;
  logic                 pgm_we;
  mcu_op_e              pgm_op;
  logic [IDX_W-1:0]     pgm_idx;
  logic [PAYLOAD_W-1:0] pgm_in;
  logic                 match_valid;
  logic                 match_hit;
  logic [DATA_W-1:0]    match_data;

  snescmd_decoder snescmd_decoder_i (
    .clk           (clk),
    .rst           (rst),
    .bus_wr_strobe (bus_wr_strobe),
    .bus_addr      (bus_addr),
    .bus_wr_data   (bus_wr_data),
    .cmd_strobe    (cmd_strobe),
    .cmd_op        (cmd_op)
  );

  mcu_prog_port #(.NUM_SLOTS(NUM_SLOTS)) mcu_prog_port_i (
    .clk        (clk),
    .rst        (rst),
    .mcu_strobe (mcu_strobe),
    .mcu_byte   (mcu_byte),
    .pgm_we     (pgm_we),
    .pgm_op     (pgm_op),
    .pgm_idx    (pgm_idx),
    .pgm_in     (pgm_in)
  );

  cheat_engine #(.NUM_SLOTS(NUM_SLOTS)) cheat_engine_i (
    .clk           (clk),
    .rst           (rst),
    .bus_rd_strobe (bus_rd_strobe),
    .bus_addr      (bus_addr),
    .cmd_strobe    (cmd_strobe),
    .cmd_op        (cmd_op),
    .pgm_we        (pgm_we),
    .pgm_op        (pgm_op),
    .pgm_idx       (pgm_idx),
    .pgm_in        (pgm_in),
    .match_valid   (match_valid),
    .match_hit     (match_hit),
    .match_data    (match_data)
  );

  rom_read_mux rom_read_mux_i (
    .clk         (clk),
    .rst         (rst),
    .match_valid (match_valid),
    .match_hit   (match_hit),
    .match_data  (match_data),
    .rom_data    (rom_data),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .cheat_hit   (cheat_hit)
  );

endmodule

//--- logic/cheat_engine.sv
`timescale 1ns/1ps

module cheat_engine
  import cart_bus_pkg::*;
  import cheat_pkg::*;
#(
  parameter int NUM_SLOTS = NUM_SLOTS_DEF
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 bus_rd_strobe,
  input  logic [ADDR_W-1:0]    bus_addr,
  input  logic                 cmd_strobe,
  input  snescmd_op_e          cmd_op,
  input  logic                 pgm_we,
  input  mcu_op_e              pgm_op,
  input  logic [IDX_W-1:0]     pgm_idx,
  input  logic [PAYLOAD_W-1:0] pgm_in,
  output logic                 match_valid,
  output logic                 match_hit,
  output logic [DATA_W-1:0]    match_data
);

  logic [NUM_SLOTS-1:0][ADDR_W-1:0] slot_addr;
  logic [NUM_SLOTS-1:0][DATA_W-1:0] slot_data;
  logic [NUM_SLOTS-1:0]             slot_mask;
  logic                             cheat_en;
  logic                             hook_en;

  logic [STAT_MASK_W-1:0] stat_mask;
  logic                   slot_wr;
  logic [NUM_SLOTS-1:0]   slot_hit;
  logic                   hook_lo;
  logic                   hook_hi;
  logic [DATA_W-1:0]      data_sel;

  ////////////////////////////////////////
  // State updates, commands first
  ////////////////////////////////////////
  assign stat_mask = pgm_in[STAT_MASK_W-1:0];
  assign slot_wr   = pgm_we && !cmd_strobe && (pgm_op == MCU_WRITE_SLOT);

  always_ff @(posedge clk) begin
    if (rst) begin
      cheat_en  <= 1'b0;
      hook_en   <= 1'b0;
      slot_mask <= '0;
    end else if (cmd_strobe) begin
      case (cmd_op)
        CMD_CHEAT_ON:  cheat_en <= 1'b1;
        CMD_CHEAT_OFF: cheat_en <= 1'b0;
        CMD_HOOK_OFF:  hook_en  <= 1'b0;
        default: ;
      endcase
    end else if (pgm_we && pgm_op == MCU_WRITE_STATUS) begin
      hook_en   <= pgm_in[STAT_HOOK_BIT];
      cheat_en  <= pgm_in[STAT_CHEAT_BIT];
      slot_mask <= stat_mask[NUM_SLOTS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (slot_wr) begin
      slot_addr[pgm_idx] <= pgm_in[SLOT_ADDR_LSB +: ADDR_W];
      slot_data[pgm_idx] <= pgm_in[DATA_W-1:0];
    end
  end

  ////////////////////////////////////////
  // Address match
  ////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot_hit[i] = cheat_en && slot_mask[i] && (bus_addr == slot_addr[i]);
    end
  end

  assign hook_lo = hook_en && (bus_addr == HOOK_VEC_LO);
  assign hook_hi = hook_en && (bus_addr == HOOK_VEC_HI);

  // Walk down so the lowest slot wins
  always_comb begin
    data_sel = hook_hi ? HOOK_DATA_HI : HOOK_DATA_LO;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (slot_hit[i]) begin
        data_sel = slot_data[i];
      end
    end
  end

  assign match_valid = bus_rd_strobe;
  assign match_hit   = bus_rd_strobe && ((|slot_hit) || hook_lo || hook_hi);
  assign match_data  = data_sel;

  a_cmd_wins : assert property (@(posedge clk) disable iff (rst)
    cmd_strobe && pgm_we |=> $stable(slot_addr) && $stable(slot_data));

endmodule

//--- logic/cheat_pkg.sv
package cheat_pkg;

  ////////////////////////////////////////
  // Slot table sizing
  ////////////////////////////////////////
  localparam int IDX_W         = 3;
  localparam int NUM_SLOTS_DEF = 6;

  // MCU frame is one header byte and four payload bytes, MSB first
  localparam int PAYLOAD_W     = 32;
  localparam int PAYLOAD_BYTES = 4;

  // Status word layout
  localparam int STAT_HOOK_BIT  = 7;
  localparam int STAT_CHEAT_BIT = 6;
  localparam int STAT_MASK_W    = 6;

  // Slot word layout, address above the data byte
  localparam int SLOT_ADDR_LSB = 8;

  // Header upper nibble
  typedef enum logic [3:0] {
    MCU_NONE         = 4'd0,
    MCU_WRITE_SLOT   = 4'd1,
    MCU_WRITE_STATUS = 4'd2
  } mcu_op_e;

endpackage

//--- logic/mcu_prog_port.sv
`timescale 1ns/1ps

module mcu_prog_port
  import cheat_pkg::*;
#(
  parameter int NUM_SLOTS = NUM_SLOTS_DEF
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 mcu_strobe,
  input  logic [7:0]           mcu_byte,
  output logic                 pgm_we,
  output mcu_op_e              pgm_op,
  output logic [IDX_W-1:0]     pgm_idx,
  output logic [PAYLOAD_W-1:0] pgm_in
);

  typedef enum logic {
    ST_HEADER,
    ST_PAYLOAD
  } state_e;

  state_e               state;
  logic [1:0]           byte_cnt;
  logic                 frame_ok;
  logic                 last_byte;
  mcu_op_e              hdr_op;
  logic                 hdr_known;
  logic                 hdr_ok;
  logic [PAYLOAD_W-1:0] payload;

  // Decode the header byte as it arrives
  always_comb begin
    hdr_op    = mcu_op_e'(mcu_byte[7:4]);
    hdr_known = 1'b1;
    hdr_ok    = 1'b0;
    case (hdr_op)
      MCU_WRITE_STATUS: hdr_ok = 1'b1;
      MCU_WRITE_SLOT:   hdr_ok = (mcu_byte[3:0] < 4'(NUM_SLOTS));
      default:          hdr_known = 1'b0;
    endcase
  end

  assign last_byte = (state == ST_PAYLOAD) && mcu_strobe &&
                     (byte_cnt == 2'(PAYLOAD_BYTES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_HEADER;
      byte_cnt <= '0;
      frame_ok <= 1'b0;
      pgm_we   <= 1'b0;
    end else begin
      pgm_we <= last_byte && frame_ok;
      if (mcu_strobe) begin
        case (state)
          ST_HEADER: begin
            // Unknown opcodes carry no payload
            if (hdr_known) begin
              state    <= ST_PAYLOAD;
              byte_cnt <= '0;
              frame_ok <= hdr_ok;
            end
          end
          ST_PAYLOAD: begin
            byte_cnt <= byte_cnt + 2'd1;
            if (last_byte) begin
              state <= ST_HEADER;
            end
          end
          default: state <= ST_HEADER;
        endcase
      end
    end
  end

  // Header fields and payload shift register
  always_ff @(posedge clk) begin
    if (mcu_strobe && state == ST_HEADER && hdr_known) begin
      pgm_op  <= hdr_op;
      pgm_idx <= mcu_byte[IDX_W-1:0];
    end
    if (mcu_strobe && state == ST_PAYLOAD) begin
      payload <= {payload[PAYLOAD_W-9:0], mcu_byte};
    end
  end

  assign pgm_in = payload;

  a_idx_range : assert property (@(posedge clk) disable iff (rst)
    pgm_we && pgm_op == MCU_WRITE_SLOT |-> pgm_idx < IDX_W'(NUM_SLOTS));

endmodule

//--- logic/rom_read_mux.sv
`timescale 1ns/1ps

module rom_read_mux
  import cart_bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              match_valid,
  input  logic              match_hit,
  input  logic [DATA_W-1:0] match_data,
  input  logic [DATA_W-1:0] rom_data,
  output logic              rd_valid,
  output logic [DATA_W-1:0] rd_data,
  output logic              cheat_hit
);

  // Response flags, one cycle after the read strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid  <= 1'b0;
      cheat_hit <= 1'b0;
    end else begin
      rd_valid  <= match_valid;
      cheat_hit <= match_valid && match_hit;
    end
  end

  // Data holds between reads
  always_ff @(posedge clk) begin
    if (match_valid) begin
      rd_data <= match_hit ? match_data : rom_data;
    end
  end

endmodule

//--- logic/snescmd_decoder.sv
`timescale 1ns/1ps

module snescmd_decoder
  import cart_bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              bus_wr_strobe,
  input  logic [ADDR_W-1:0] bus_addr,
  input  logic [DATA_W-1:0] bus_wr_data,
  output logic              cmd_strobe,
  output snescmd_op_e       cmd_op
);

  logic        win_hit;
  snescmd_op_e op_dec;

  assign win_hit = bus_wr_strobe && (bus_addr == CMD_WINDOW_BASE);

  // Only known commands pass through, everything else is a no-op
  always_comb begin
    case (bus_wr_data)
      CMD_CHEAT_ON, CMD_CHEAT_OFF, CMD_HOOK_OFF: op_dec = snescmd_op_e'(bus_wr_data);
      default: op_dec = CMD_NONE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_strobe <= 1'b0;
    end else begin
      cmd_strobe <= win_hit;
    end
  end

  // Opcode only matters alongside cmd_strobe
  always_ff @(posedge clk) begin
    if (win_hit) begin
      cmd_op <= op_dec;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // Two strobes in a row need two console writes in a row
  a_cmd_b2b : assert property (@(posedge clk) disable iff (rst)
    cmd_strobe && $past(cmd_strobe) |-> $past(bus_wr_strobe) && $past(bus_wr_strobe, 2));

endmodule

//--- vlog.f
logic/cart_bus_pkg.sv
logic/cheat_pkg.sv
logic/snescmd_decoder.sv
logic/mcu_prog_port.sv
logic/cheat_engine.sv
logic/rom_read_mux.sv
logic/cart_cheat_top.sv
bench/cart_cheat_tb.sv
